// ==== src.f ====
+incdir+verif
verilog/mult_pkg.sv
verilog/mult_controller.sv
verilog/mult_datapath.sv
verilog/taint_mult_top.sv
verif/tb_taint_mult.sv

// ==== verif/tb_taint_mult_checks.svh ====
//====================================================================
// Reference model functions and concurrent checks for the multiplier
//====================================================================

`ifndef TB_TAINT_MULT_CHECKS_SVH
`define TB_TAINT_MULT_CHECKS_SVH

// Busy cycles between the accepted start and done
localparam int RUN_LEN = 2 * WIDTH + 1;

//====================================================================
// Reference model
//====================================================================

function automatic logic [2*WIDTH-1:0] expected_product(
    input logic [WIDTH-1:0] mr,
    input logic [WIDTH-1:0] md
);
    return {{WIDTH{1'b0}}, mr} * {{WIDTH{1'b0}}, md};
endfunction

// Multiplicand only matters when some add actually happens
function automatic logic expected_taint(
    input logic             st,
    input logic             mr_t,
    input logic             md_t,
    input logic [WIDTH-1:0] mr
);
    return st | mr_t | (md_t & (mr != '0));
endfunction

//====================================================================
// Checks
//====================================================================

a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !first_start_seen |-> (!busy && !done)
) else log_error("busy or done high before the first start");

a_done_timing: assert property (@(posedge clk) disable iff (!rst_n)
    (start && !busy) |=> busy [*RUN_LEN] ##1 done
) else log_error("done not on time or busy dropped during the run");

a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done
) else log_error("done longer than one cycle");

// No second run sneaks in from a start seen while busy
a_no_extra_run: assert property (@(posedge clk) disable iff (!rst_n)
    (done && !start) |=> !busy
) else log_error("busy after done without a new start");

a_product: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (product == expected_product(multiplier, multiplicand))
) else log_error("product differs from multiplier times multiplicand");

a_product_taint: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (product_t == expected_taint(op_start_t, multiplier_t,
                                           multiplicand_t, multiplier))
) else log_error("product taint differs from expected taint");

a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |=> ($stable(product) && $stable(product_t))
) else log_error("result changed while no run was active");

`endif

// ==== verif/tb_taint_mult.sv ====
//====================================================================
// Testbench for the taint-tracking multiplier
// Fixed and random operations, start while busy, timeout, report
//====================================================================

`default_nettype none

module tb_taint_mult
    import mult_pkg::*;
;

    localparam int WIDTH          = 8;
    localparam int TIMEOUT_CYCLES = 50 * (2 * WIDTH + 4) + 100;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic               start_t;
    logic [WIDTH-1:0]   multiplier;
    logic               multiplier_t;
    logic [WIDTH-1:0]   multiplicand;
    logic               multiplicand_t;
    logic               busy;
    logic               done;
    logic [2*WIDTH-1:0] product;
    logic               product_t;

    // Start taint of the run in progress
    logic               op_start_t;
    logic               first_start_seen;
    logic [4:0]         states_seen;
    int                 error_count;
    int                 cycle_count;
    integer             seed;

    task automatic log_error(input string msg);
        error_count++;
        $display("ERROR at time %0t: %s", $time, msg);
    endtask

    `include "tb_taint_mult_checks.svh"

    taint_mult_top #(
        .WIDTH (WIDTH)
    ) dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .start_t        (start_t),
        .multiplier     (multiplier),
        .multiplier_t   (multiplier_t),
        .multiplicand   (multiplicand),
        .multiplicand_t (multiplicand_t),
        .busy           (busy),
        .done           (done),
        .product        (product),
        .product_t      (product_t)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Controller state coverage
    always @(posedge clk) begin
        states_seen[int'(dut.u_controller.state)] <= 1'b1;
    end

    //====================================================================
    // Stimulus tasks
    //====================================================================

    // Returns at the edge where start is sampled
    task automatic begin_op(
        input logic [WIDTH-1:0] mr,
        input logic [WIDTH-1:0] md,
        input logic             st,
        input logic             mr_t,
        input logic             md_t
    );
        @(posedge clk);
        multiplier       <= mr;
        multiplier_t     <= mr_t;
        multiplicand     <= md;
        multiplicand_t   <= md_t;
        start            <= 1'b1;
        start_t          <= st;
        op_start_t       <= st;
        first_start_seen <= 1'b1;
        @(posedge clk);
        start   <= 1'b0;
        start_t <= 1'b0;
    endtask

    task automatic wait_done();
        while (done !== 1'b1) begin
            @(posedge clk);
        end
    endtask

    task automatic run_op(
        input logic [WIDTH-1:0] mr,
        input logic [WIDTH-1:0] md,
        input logic             st,
        input logic             mr_t,
        input logic             md_t
    );
        begin_op(mr, md, st, mr_t, md_t);
        wait_done();
    endtask

    //====================================================================
    // Test sequence
    //====================================================================

    initial begin
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        logic [31:0] rnd_t;

        seed             = 35;
        error_count      = 0;
        states_seen      = '0;
        rst_n            <= 1'b0;
        start            <= 1'b0;
        start_t          <= 1'b0;
        multiplier       <= '0;
        multiplier_t     <= 1'b0;
        multiplicand     <= '0;
        multiplicand_t   <= 1'b0;
        op_start_t       <= 1'b0;
        first_start_seen <= 1'b0;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);

        // Fixed cases walk all eight taint combinations
        run_op(8'd0,   8'd0,   1'b0, 1'b0, 1'b0);
        run_op(8'd0,   8'd9,   1'b0, 1'b0, 1'b1);
        run_op(8'd1,   8'd1,   1'b0, 1'b1, 1'b0);
        run_op(8'd1,   8'd173, 1'b0, 1'b1, 1'b1);
        run_op(8'd255, 8'd255, 1'b1, 1'b0, 1'b0);
        run_op(8'd128, 8'd2,   1'b1, 1'b0, 1'b1);
        run_op(8'd16,  8'd64,  1'b1, 1'b1, 1'b0);
        run_op(8'd2,   8'd128, 1'b1, 1'b1, 1'b1);

        for (int i = 0; i < 40; i++) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            rnd_t = $random(seed);
            // Occasional zero multiplier
            if (rnd_t[5:3] == 3'd0) begin
                rnd_a = '0;
            end
            run_op(rnd_a[WIDTH-1:0], rnd_b[WIDTH-1:0], rnd_t[0], rnd_t[1], rnd_t[2]);
        end

        // Tainted start pulse in the middle of a clean run
        begin_op(8'd200, 8'd3, 1'b0, 1'b0, 1'b0);
        repeat (5) @(posedge clk);
        start   <= 1'b1;
        start_t <= 1'b1;
        @(posedge clk);
        start   <= 1'b0;
        start_t <= 1'b0;
        wait_done();
        repeat (4) @(posedge clk);

        if (!(states_seen[IDLE] && states_seen[LOAD] && states_seen[ADD]
              && states_seen[SHIFT] && states_seen[DONE])) begin
            error_count++;
            $display("The controller did not pass through every state");
        end

        $display("Finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    //====================================================================
    // Timeout
    //====================================================================

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles before the tests completed", cycle_count);
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_taint_mult

`default_nettype wire

// ==== verilog/mult_controller.sv ====
//====================================================================
// Shift-and-add multiplier controller
// Sequences load, clear, add and shift strobes with their taints
//====================================================================

`default_nettype none

module mult_controller
    import mult_pkg::*;
#(
    parameter int WIDTH
) (
    input  wire              clk,
    input  wire              rst_n,

    // Operation request
    input  wire              start,
    input  wire              start_t,

    // Multiplier word held in the datapath
    input  wire [WIDTH-1:0]  multiplier_reg,
    input  wire              multiplier_reg_t,

    // Status
    output logic             busy,
    output logic             done,

    // Strobes to the datapath, each with its own taint
    output logic             mrld,
    output logic             mrld_t,
    output logic             mdld,
    output logic             mdld_t,
    output logic             rsclear,
    output logic             rsclear_t,
    output logic             rsload,
    output logic             rsload_t,
    output logic             rsshr,
    output logic             rsshr_t
);

    // Step counter walks multiplier bits 0 to WIDTH-1
    localparam int STEP_W = $clog2(WIDTH);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(WIDTH - 1);

    mult_state_e        state;
    mult_state_e        state_next;
    logic [STEP_W-1:0]  step;
    logic               run_t;
    logic               start_ok;
    logic               cur_bit;

    // Start is taken only when no run is in progress
    assign start_ok = start && ((state == IDLE) || (state == DONE));

    // Multiplier bit deciding the current add
    assign cur_bit = multiplier_reg[step];

    //====================================================================
    // State register and next-state logic
    //====================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start_ok) begin
                    state_next = LOAD;
                end
            end
            LOAD:  state_next = ADD;
            ADD:   state_next = SHIFT;
            SHIFT: begin
                if (step == LAST_STEP) begin
                    state_next = DONE;
                end else begin
                    state_next = ADD;
                end
            end
            // Back-to-back start skips IDLE
            DONE:    state_next = start_ok ? LOAD : IDLE;
            default: state_next = IDLE;
        endcase
    end

    //====================================================================
    // Step counter and run taint
    //====================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step <= '0;
        end else if (state == LOAD) begin
            step <= '0;
        end else if ((state == SHIFT) && (step != LAST_STEP)) begin
            step <= step + 1'b1;
        end
    end

    // Taint of the request itself, kept for the whole run
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_t <= 1'b0;
        end else if (start_ok) begin
            run_t <= start_t;
        end
    end

    //====================================================================
    // Strobe decode
    //====================================================================

    always_comb begin
        mrld      = 1'b0;
        mrld_t    = 1'b0;
        mdld      = 1'b0;
        mdld_t    = 1'b0;
        rsclear   = 1'b0;
        rsclear_t = 1'b0;
        rsload    = 1'b0;
        rsload_t  = 1'b0;
        rsshr     = 1'b0;
        rsshr_t   = 1'b0;
        case (state)
            LOAD: begin
                mrld      = 1'b1;
                mrld_t    = run_t;
                mdld      = 1'b1;
                mdld_t    = run_t;
                rsclear   = 1'b1;
                rsclear_t = run_t;
            end
            ADD: begin
                rsload   = cur_bit;
                // Choice to add depends on a possibly tainted bit
                rsload_t = run_t | multiplier_reg_t;
            end
            SHIFT: begin
                rsshr   = 1'b1;
                rsshr_t = run_t;
            end
            default: begin
            end
        endcase
    end

    assign busy = (state == LOAD) || (state == ADD) || (state == SHIFT);
    assign done = (state == DONE);

    //====================================================================
    // Assertions
    //====================================================================

    a_add_shift_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(rsload && rsshr)
    ) else $error("rsload and rsshr high together");

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    ) else $error("done held for more than one cycle");

    a_idle_quiet: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == IDLE) |-> !(mrld || mdld || rsclear || rsload || rsshr)
    ) else $error("strobe issued in IDLE");

endmodule : mult_controller

`default_nettype wire

// ==== verilog/mult_datapath.sv ====
//====================================================================
// Shift-and-add multiplier datapath
// Operand and running-sum registers with sticky one-bit taints
//====================================================================

`default_nettype none

module mult_datapath #(
    parameter int WIDTH
) (
    input  wire                clk,
    input  wire                rst_n,

    // Operands from outside
    input  wire [WIDTH-1:0]    multiplier,
    input  wire                multiplier_t,
    input  wire [WIDTH-1:0]    multiplicand,
    input  wire                multiplicand_t,

    // Strobes from the controller
    input  wire                mrld,
    input  wire                mrld_t,
    input  wire                mdld,
    input  wire                mdld_t,
    input  wire                rsclear,
    input  wire                rsclear_t,
    input  wire                rsload,
    input  wire                rsload_t,
    input  wire                rsshr,
    input  wire                rsshr_t,

    // Multiplier word back to the controller
    output logic [WIDTH-1:0]   multiplier_reg,
    output logic               multiplier_reg_t,

    // Result
    output logic [2*WIDTH-1:0] product,
    output logic               product_t
);

    // One extra bit catches the carry of each add
    localparam int SUM_W = 2 * WIDTH + 1;

    logic [SUM_W-1:0] md_reg;
    logic             md_reg_t;
    logic [SUM_W-1:0] rs_reg;
    logic             rs_reg_t;
    logic [SUM_W-1:0] md_ext;
    logic             strobe_t;

    // Multiplicand aligned to the upper half
    assign md_ext = {1'b0, multiplicand, {WIDTH{1'b0}}};

    // Taint of all running-sum strobes present this cycle
    assign strobe_t = rsclear_t | rsload_t | rsshr_t;

    //====================================================================
    // Operand registers
    //====================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            multiplier_reg   <= '0;
            multiplier_reg_t <= 1'b0;
        end else if (mrld) begin
            multiplier_reg   <= multiplier;
            multiplier_reg_t <= multiplier_t | mrld_t;
        end else begin
            multiplier_reg_t <= multiplier_reg_t | mrld_t;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            md_reg   <= '0;
            md_reg_t <= 1'b0;
        end else if (mdld) begin
            md_reg   <= md_ext;
            md_reg_t <= multiplicand_t | mdld_t;
        end else begin
            md_reg_t <= md_reg_t | mdld_t;
        end
    end

    //====================================================================
    // Running sum
    //====================================================================

    // Clear wins over add, add wins over shift
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rs_reg   <= '0;
            rs_reg_t <= 1'b0;
        end else if (rsclear) begin
            rs_reg   <= '0;
            // Cleared sum carries only the taint of the clear decision
            rs_reg_t <= rsclear_t;
        end else if (rsload) begin
            rs_reg   <= rs_reg + md_reg;
            rs_reg_t <= rs_reg_t | md_reg_t | strobe_t;
        end else if (rsshr) begin
            rs_reg   <= rs_reg >> 1;
            rs_reg_t <= rs_reg_t | strobe_t;
        end else begin
            // A skipped add still leaks the taint of its decision
            rs_reg_t <= rs_reg_t | strobe_t;
        end
    end

    assign product   = rs_reg[2*WIDTH-1:0];
    assign product_t = rs_reg_t;

    //====================================================================
    // Assertions
    //====================================================================

    a_load_pair: assert property (
        @(posedge clk) disable iff (!rst_n)
        mrld == mdld
    ) else $error("multiplier and multiplicand loads out of step");

endmodule : mult_datapath

`default_nettype wire

// ==== verilog/mult_pkg.sv ====
//====================================================================
// Shared definitions for the taint-tracking multiplier
// Controller state encoding and default operand width
//====================================================================

`default_nettype none

package mult_pkg;

    //====================================================================
    // Sizing
    //====================================================================

    // Operand width used when the top level is not overridden
    localparam int DEFAULT_WIDTH = 32;

    //====================================================================
    // Controller states
    //====================================================================

    // LOAD once, then WIDTH pairs of ADD and SHIFT, then DONE
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        LOAD  = 3'd1,
        ADD   = 3'd2,
        SHIFT = 3'd3,
        DONE  = 3'd4
    } mult_state_e;

endpackage : mult_pkg

`default_nettype wire

// ==== verilog/taint_mult_top.sv ====
//====================================================================
// Top level of the taint-tracking sequential multiplier
//====================================================================

`default_nettype none

module taint_mult_top
    import mult_pkg::*;
#(
    parameter int WIDTH = DEFAULT_WIDTH
) (
    input  wire                clk,
    input  wire                rst_n,

    // Request and operands, each with its taint
    input  wire                start,
    input  wire                start_t,
    input  wire [WIDTH-1:0]    multiplier,
    input  wire                multiplier_t,
    input  wire [WIDTH-1:0]    multiplicand,
    input  wire                multiplicand_t,

    // Status and result
    output logic               busy,
    output logic               done,
    output logic [2*WIDTH-1:0] product,
    output logic               product_t
);

    //====================================================================
    // Controller to datapath strobes
    //====================================================================

    logic             mrld;
    logic             mrld_t;
    logic             mdld;
    logic             mdld_t;
    logic             rsclear;
    logic             rsclear_t;
    logic             rsload;
    logic             rsload_t;
    logic             rsshr;
    logic             rsshr_t;

    // Multiplier word fed back for bit selection
    logic [WIDTH-1:0] multiplier_reg;
    logic             multiplier_reg_t;

    mult_controller #(
        .WIDTH (WIDTH)
    ) u_controller (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .start_t          (start_t),
        .multiplier_reg   (multiplier_reg),
        .multiplier_reg_t (multiplier_reg_t),
        .busy             (busy),
        .done             (done),
        .mrld             (mrld),
        .mrld_t           (mrld_t),
        .mdld             (mdld),
        .mdld_t           (mdld_t),
        .rsclear          (rsclear),
        .rsclear_t        (rsclear_t),
        .rsload           (rsload),
        .rsload_t         (rsload_t),
        .rsshr            (rsshr),
        .rsshr_t          (rsshr_t)
    );

    mult_datapath #(
        .WIDTH (WIDTH)
    ) u_datapath (
        .clk              (clk),
        .rst_n            (rst_n),
        .multiplier       (multiplier),
        .multiplier_t     (multiplier_t),
        .multiplicand     (multiplicand),
        .multiplicand_t   (multiplicand_t),
        .mrld             (mrld),
        .mrld_t           (mrld_t),
        .mdld             (mdld),
        .mdld_t           (mdld_t),
        .rsclear          (rsclear),
        .rsclear_t        (rsclear_t),
        .rsload           (rsload),
        .rsload_t         (rsload_t),
        .rsshr            (rsshr),
        .rsshr_t          (rsshr_t),
        .multiplier_reg   (multiplier_reg),
        .multiplier_reg_t (multiplier_reg_t),
        .product          (product),
        .product_t        (product_t)
    );

endmodule : taint_mult_top

`default_nettype wire
